//--- include/trace_settings.svh
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// number of records held by the trace buffer
`define TRACE_FIFO_DEPTH 8

////////////////////////////////////////
// apb register byte offsets
////////////////////////////////////////

`define TRACE_ADDR_CTRL   8'h00
`define TRACE_ADDR_STATUS 8'h04
`define TRACE_ADDR_PC     8'h08
`define TRACE_ADDR_INSTR  8'h0C
`define TRACE_ADDR_INFO   8'h10
`define TRACE_ADDR_IMM    8'h14
`define TRACE_ADDR_WDATA  8'h18
// last word of a record, reading it pops the head
`define TRACE_ADDR_CYCLE  8'h1C

`endif

//--- hdl/trace_pkg.sv
`default_nettype none

package trace_pkg;

    ////////////////////////////////////////
    // rv32i base opcodes
    ////////////////////////////////////////

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    ////////////////////////////////////////
    // instruction layouts
    ////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    // b and j scatter their immediate bits
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_fmt_u;

    typedef enum logic [3:0] {
        CLASS_INVALID = 4'd0,
        CLASS_ALU_R   = 4'd1,
        CLASS_ALU_I   = 4'd2,
        CLASS_LOAD    = 4'd3,
        CLASS_STORE   = 4'd4,
        CLASS_BRANCH  = 4'd5,
        CLASS_JAL     = 4'd6,
        CLASS_JALR    = 4'd7,
        CLASS_UPPER   = 4'd8,
        CLASS_SYSTEM  = 4'd9
    } instr_class_e;

    // one buffered trace entry
    typedef struct packed {
        logic [31:0]  pc;
        logic [31:0]  instr;
        instr_class_e iclass;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        logic         wb_valid;
        logic [31:0]  imm;
        logic [31:0]  wdata;
        logic [31:0]  cycle;
    } trace_rec_t;

endpackage

`default_nettype wire

//--- hdl/trace_fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

// valid/ready record channel, level reports buffer occupancy
interface trace_fifo_if;

    logic                                     valid;
    logic                                     ready;
    trace_pkg::trace_rec_t                    rec;
    logic [$clog2(`TRACE_FIFO_DEPTH + 1)-1:0] level;

    // producing side, holds rec while valid and not ready
    modport source (
        output valid,
        output rec,
        output level,
        input  ready
    );

    modport sink (
        input  valid,
        input  rec,
        input  level,
        output ready
    );

endinterface

`default_nettype wire

//--- hdl/trace_capture.sv
`timescale 1ns/1ps
`default_nettype none

module trace_capture (
    input  wire              clk_i,
    input  wire              rst_ni,
    input  wire              retire_valid_i,
    input  wire [31:0]       retire_pc_i,
    input  wire [31:0]       retire_instr_i,
    input  wire              retire_rd_we_i,
    input  wire [31:0]       retire_rd_wdata_i,
    input  wire              enable_i,
    trace_fifo_if.source     push,
    output logic [7:0]       drop_count_o
);

    trace_pkg::instr_fmt_u   instr;
    trace_pkg::instr_class_e iclass;
    trace_pkg::trace_rec_t   rec_d;
    logic [4:0]              rd;
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [31:0]             imm;
    logic                    wb_valid;
    logic                    accept;
    logic                    load;
    logic [31:0]             cycle_q;

    assign instr = retire_instr_i;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    always_comb begin
        case (instr.r.opcode)
            trace_pkg::OPC_OP:     iclass = trace_pkg::CLASS_ALU_R;
            trace_pkg::OPC_OP_IMM: iclass = trace_pkg::CLASS_ALU_I;
            trace_pkg::OPC_LOAD:   iclass = trace_pkg::CLASS_LOAD;
            trace_pkg::OPC_STORE:  iclass = trace_pkg::CLASS_STORE;
            trace_pkg::OPC_BRANCH: iclass = trace_pkg::CLASS_BRANCH;
            trace_pkg::OPC_JAL:    iclass = trace_pkg::CLASS_JAL;
            trace_pkg::OPC_JALR:   iclass = trace_pkg::CLASS_JALR;
            trace_pkg::OPC_LUI:    iclass = trace_pkg::CLASS_UPPER;
            trace_pkg::OPC_AUIPC:  iclass = trace_pkg::CLASS_UPPER;
            trace_pkg::OPC_SYSTEM: iclass = trace_pkg::CLASS_SYSTEM;
            default:               iclass = trace_pkg::CLASS_INVALID;
        endcase
    end

    // fields the format lacks stay zero
    always_comb begin
        rd  = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        case (iclass)
            trace_pkg::CLASS_ALU_R: begin
                rd  = instr.r.rd;
                rs1 = instr.r.rs1;
                rs2 = instr.r.rs2;
            end
            trace_pkg::CLASS_ALU_I, trace_pkg::CLASS_LOAD, trace_pkg::CLASS_JALR: begin
                rd  = instr.i.rd;
                rs1 = instr.i.rs1;
                imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            trace_pkg::CLASS_STORE: begin
                rs1 = instr.s.rs1;
                rs2 = instr.s.rs2;
                imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            end
            trace_pkg::CLASS_BRANCH: begin
                rs1 = instr.b.rs1;
                rs2 = instr.b.rs2;
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            trace_pkg::CLASS_JAL: begin
                rd  = instr.j.rd;
                imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            trace_pkg::CLASS_UPPER: begin
                rd  = instr.u.rd;
                imm = {instr.u.imm_31_12, 12'h000};
            end
            // zero extended csr number
            trace_pkg::CLASS_SYSTEM: begin
                rd  = instr.i.rd;
                rs1 = instr.i.rs1;
                imm = {20'h00000, instr.i.imm_11_0};
            end
            default: begin
            end
        endcase
    end

    // writes to x0 are not real writebacks
    assign wb_valid = retire_rd_we_i && (rd != 5'd0);

    always_comb begin
        rec_d.pc       = retire_pc_i;
        rec_d.instr    = retire_instr_i;
        rec_d.iclass   = iclass;
        rec_d.rd       = rd;
        rec_d.rs1      = rs1;
        rec_d.rs2      = rs2;
        rec_d.wb_valid = wb_valid;
        rec_d.imm      = imm;
        rec_d.wdata    = wb_valid ? retire_rd_wdata_i : 32'h0;
        rec_d.cycle    = cycle_q;
    end

    ////////////////////////////////////////
    // record register and counters
    ////////////////////////////////////////

    assign accept = enable_i && retire_valid_i;
    // only a stalled record blocks a new one
    assign load   = accept && (push.ready || !push.valid);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            push.valid <= 1'b0;
        end else if (load) begin
            push.valid <= 1'b1;
        end else if (push.ready) begin
            push.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            push.rec <= rec_d;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 32'd1;
        end
    end

    // saturating count of events lost behind a stalled record
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            drop_count_o <= '0;
        end else if (accept && !load && (drop_count_o != 8'hFF)) begin
            drop_count_o <= drop_count_o + 8'd1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/trace_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module trace_fifo (
    input  wire          clk_i,
    input  wire          rst_ni,
    trace_fifo_if.sink   push,
    trace_fifo_if.source pop
);

    localparam int unsigned depth = `TRACE_FIFO_DEPTH;
    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int unsigned cnt_w = $clog2(depth + 1);

    trace_pkg::trace_rec_t mem [depth];
    logic [ptr_w-1:0]      wr_ptr_q;
    logic [ptr_w-1:0]      rd_ptr_q;
    logic [cnt_w-1:0]      count_q;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push.valid && push.ready;
    assign do_pop  = pop.valid && pop.ready;

    // ready only drops when every slot is taken
    assign push.ready = (count_q != cnt_w'(depth));
    assign pop.valid  = (count_q != '0);
    assign pop.rec    = mem[rd_ptr_q];
    assign pop.level  = count_q;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push.rec;
        end
    end

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/trace_apb_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module trace_apb_reader (
    input  wire          clk_i,
    input  wire          rst_ni,
    input  wire [7:0]    paddr_i,
    input  wire          psel_i,
    input  wire          penable_i,
    input  wire          pwrite_i,
    input  wire [31:0]   pwdata_i,
    output logic [31:0]  prdata_o,
    output logic         pslverr_o,
    trace_fifo_if.sink   pop,
    input  wire [7:0]    drop_count_i,
    output logic         enable_o
);

    logic        access;
    logic        mapped;
    logic        rec_word;
    logic        err;
    logic [31:0] rdata;
    logic        enable_q;

    // zero wait states, everything resolves in the access phase
    assign access = psel_i && penable_i;

    ////////////////////////////////////////
    // read mux
    ////////////////////////////////////////

    always_comb begin
        rdata    = '0;
        mapped   = 1'b1;
        rec_word = 1'b0;
        case (paddr_i)
            `TRACE_ADDR_CTRL: begin
                rdata = {31'h0, enable_q};
            end
            `TRACE_ADDR_STATUS: begin
                rdata = {16'h0, drop_count_i, 8'(pop.level)};
            end
            `TRACE_ADDR_PC: begin
                rec_word = 1'b1;
                rdata    = pop.rec.pc;
            end
            `TRACE_ADDR_INSTR: begin
                rec_word = 1'b1;
                rdata    = pop.rec.instr;
            end
            `TRACE_ADDR_INFO: begin
                rec_word = 1'b1;
                rdata    = {pop.rec.wb_valid, 2'b00, pop.rec.rs2, 3'b000, pop.rec.rs1,
                            3'b000, pop.rec.rd, 4'h0, pop.rec.iclass};
            end
            `TRACE_ADDR_IMM: begin
                rec_word = 1'b1;
                rdata    = pop.rec.imm;
            end
            `TRACE_ADDR_WDATA: begin
                rec_word = 1'b1;
                rdata    = pop.rec.wdata;
            end
            `TRACE_ADDR_CYCLE: begin
                rec_word = 1'b1;
                rdata    = pop.rec.cycle;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
        // no head record to show
        if (rec_word && !pop.valid) begin
            rdata = '0;
        end
    end

    // unmapped, read-only or empty-buffer accesses
    assign err = !mapped
               || (pwrite_i && (paddr_i != `TRACE_ADDR_CTRL))
               || (!pwrite_i && rec_word && !pop.valid);

    assign prdata_o  = (access && !pwrite_i) ? rdata : 32'h0;
    assign pslverr_o = access && err;

    // head leaves once its last word has been read
    assign pop.ready = access && !pwrite_i && (paddr_i == `TRACE_ADDR_CYCLE) && pop.valid;

    ////////////////////////////////////////
    // ctrl register
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b0;
        end else if (access && pwrite_i && (paddr_i == `TRACE_ADDR_CTRL)) begin
            enable_q <= pwdata_i[0];
        end
    end

    assign enable_o = enable_q;

endmodule

`default_nettype wire

//--- hdl/trace_unit.sv
`timescale 1ns/1ps
`default_nettype none

module trace_unit (
    input  wire         clk_i,
    input  wire         rst_ni,
    // retire side
    input  wire         retire_valid_i,
    input  wire [31:0]  retire_pc_i,
    input  wire [31:0]  retire_instr_i,
    input  wire         retire_rd_we_i,
    input  wire [31:0]  retire_rd_wdata_i,
    // apb slave
    input  wire [7:0]   paddr_i,
    input  wire         psel_i,
    input  wire         penable_i,
    input  wire         pwrite_i,
    input  wire [31:0]  pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pslverr_o
);

    logic       enable;
    logic [7:0] drop_count;

    trace_fifo_if push_if ();
    trace_fifo_if pop_if ();

    // buffer fill level also shown on the producer channel
    assign push_if.level = pop_if.level;

    trace_capture i_capture (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .retire_valid_i    (retire_valid_i),
        .retire_pc_i       (retire_pc_i),
        .retire_instr_i    (retire_instr_i),
        .retire_rd_we_i    (retire_rd_we_i),
        .retire_rd_wdata_i (retire_rd_wdata_i),
        .enable_i          (enable),
        .push              (push_if.source),
        .drop_count_o      (drop_count)
    );

    trace_fifo i_fifo (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .push   (push_if.sink),
        .pop    (pop_if.source)
    );

    trace_apb_reader i_reader (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .paddr_i      (paddr_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pslverr_o    (pslverr_o),
        .pop          (pop_if.sink),
        .drop_count_i (drop_count),
        .enable_o     (enable)
    );

endmodule

`default_nettype wire

//--- tb/trace_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module trace_unit_assertions (
    input wire                                     clk_i,
    input wire                                     rst_ni,
    input wire                                     push_valid_i,
    input wire                                     push_ready_i,
    input wire trace_pkg::trace_rec_t              push_rec_i,
    input wire                                     pop_valid_i,
    input wire                                     pop_ready_i,
    input wire trace_pkg::trace_rec_t              pop_rec_i,
    input wire [$clog2(`TRACE_FIFO_DEPTH + 1)-1:0] level_i,
    input wire                                     psel_i,
    input wire                                     penable_i,
    input wire                                     pslverr_i
);

    ////////////////////////////////////////
    // record channels
    ////////////////////////////////////////

    // a stalled record stays put until taken
    push_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_valid_i && !push_ready_i |=> push_valid_i && $stable(push_rec_i))
        else $error("push record changed while stalled");

    pop_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_valid_i && !pop_ready_i |=> pop_valid_i && $stable(pop_rec_i))
        else $error("head record changed while stalled");

    level_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        level_i <= `TRACE_FIFO_DEPTH)
        else $error("buffer level above depth");

    ////////////////////////////////////////
    // apb
    ////////////////////////////////////////

    slverr_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pslverr_i |-> (psel_i && penable_i))
        else $error("pslverr outside access phase");

endmodule

`default_nettype wire

//--- tb/tb_trace_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module tb_trace_unit;

    localparam int NUM_ROWS       = 12;
    localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + 200;

    logic        clk_i;
    logic        rst_ni;
    logic        retire_valid_i;
    logic [31:0] retire_pc_i;
    logic [31:0] retire_instr_i;
    logic        retire_rd_we_i;
    logic [31:0] retire_rd_wdata_i;
    logic [7:0]  paddr_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [31:0] pwdata_i;
    wire [31:0]  prdata_o;
    wire         pslverr_o;

    int          cycle_count;
    logic [31:0] rng_state;

    // stimulus and expected decode per row
    logic [31:0] tab_instr [NUM_ROWS];
    logic [31:0] tab_pc    [NUM_ROWS];
    logic        tab_we    [NUM_ROWS];
    logic [31:0] tab_wdata [NUM_ROWS];
    logic [3:0]  tab_cls   [NUM_ROWS];
    logic [4:0]  tab_rd    [NUM_ROWS];
    logic [4:0]  tab_rs1   [NUM_ROWS];
    logic [4:0]  tab_rs2   [NUM_ROWS];
    logic [31:0] tab_imm   [NUM_ROWS];
    logic        tab_wb    [NUM_ROWS];

    trace_unit i_dut (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .retire_valid_i    (retire_valid_i),
        .retire_pc_i       (retire_pc_i),
        .retire_instr_i    (retire_instr_i),
        .retire_rd_we_i    (retire_rd_we_i),
        .retire_rd_wdata_i (retire_rd_wdata_i),
        .paddr_i           (paddr_i),
        .psel_i            (psel_i),
        .penable_i         (penable_i),
        .pwrite_i          (pwrite_i),
        .pwdata_i          (pwdata_i),
        .prdata_o          (prdata_o),
        .pslverr_o         (pslverr_o)
    );

    bind trace_unit trace_unit_assertions i_assertions (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_valid_i (push_if.valid),
        .push_ready_i (push_if.ready),
        .push_rec_i   (push_if.rec),
        .pop_valid_i  (pop_if.valid),
        .pop_ready_i  (pop_if.ready),
        .pop_rec_i    (pop_if.rec),
        .level_i      (pop_if.level),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pslverr_i    (pslverr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "simulation timed out");
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h",
                     $time, name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic set_row(input int idx, input logic [31:0] instr, input logic we,
                           input logic [3:0] cls, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [31:0] imm, input logic wb);
        tab_instr[idx] = instr;
        tab_pc[idx]    = 32'h0000_1000 + 32'(idx) * 32'd4;
        tab_we[idx]    = we;
        tab_cls[idx]   = cls;
        tab_rd[idx]    = rd;
        tab_rs1[idx]   = rs1;
        tab_rs2[idx]   = rs2;
        tab_imm[idx]   = imm;
        tab_wb[idx]    = wb;
        rng_state      = xorshift32(rng_state);
        tab_wdata[idx] = rng_state;
    endtask

    // add, addi, lw, sw, beq, jal +/-, jalr, lui, auipc, csrrs, unknown opcode
    task automatic load_table();
        set_row(0,  32'h002081B3, 1'b1, trace_pkg::CLASS_ALU_R,   5'd3,  5'd1, 5'd2,
                32'h0000_0000, 1'b1);
        set_row(1,  32'hFFF30293, 1'b1, trace_pkg::CLASS_ALU_I,   5'd5,  5'd6, 5'd0,
                32'hFFFF_FFFF, 1'b1);
        set_row(2,  32'h00812383, 1'b1, trace_pkg::CLASS_LOAD,    5'd7,  5'd2, 5'd0,
                32'h0000_0008, 1'b1);
        set_row(3,  32'hFE942E23, 1'b0, trace_pkg::CLASS_STORE,   5'd0,  5'd8, 5'd9,
                32'hFFFF_FFFC, 1'b0);
        set_row(4,  32'hFE208CE3, 1'b0, trace_pkg::CLASS_BRANCH,  5'd0,  5'd1, 5'd2,
                32'hFFFF_FFF8, 1'b0);
        set_row(5,  32'h001000EF, 1'b1, trace_pkg::CLASS_JAL,     5'd1,  5'd0, 5'd0,
                32'h0000_0800, 1'b1);
        // jal x0 with write enable, no real writeback
        set_row(6,  32'hFFDFF06F, 1'b1, trace_pkg::CLASS_JAL,     5'd0,  5'd0, 5'd0,
                32'hFFFF_FFFC, 1'b0);
        set_row(7,  32'hFFE280E7, 1'b1, trace_pkg::CLASS_JALR,    5'd1,  5'd5, 5'd0,
                32'hFFFF_FFFE, 1'b1);
        set_row(8,  32'h12345537, 1'b1, trace_pkg::CLASS_UPPER,   5'd10, 5'd0, 5'd0,
                32'h1234_5000, 1'b1);
        set_row(9,  32'hFFFFF597, 1'b1, trace_pkg::CLASS_UPPER,   5'd11, 5'd0, 5'd0,
                32'hFFFF_F000, 1'b1);
        set_row(10, 32'hB0002673, 1'b1, trace_pkg::CLASS_SYSTEM,  5'd12, 5'd0, 5'd0,
                32'h0000_0B00, 1'b1);
        set_row(11, 32'hFFFFFFFF, 1'b1, trace_pkg::CLASS_INVALID, 5'd0,  5'd0, 5'd0,
                32'h0000_0000, 1'b0);
    endtask

    ////////////////////////////////////////
    // bus and retire drivers
    ////////////////////////////////////////

    // all drivers start and end 1 ns after a rising edge
    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        paddr_i   = addr;
        pwrite_i  = 1'b0;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        @(posedge clk_i);
        #1 penable_i = 1'b1;
        @(negedge clk_i);
        data = prdata_o;
        err  = pslverr_o;
        @(posedge clk_i);
        #1 psel_i = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        paddr_i   = addr;
        pwrite_i  = 1'b1;
        pwdata_i  = data;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        @(posedge clk_i);
        #1 penable_i = 1'b1;
        @(negedge clk_i);
        err = pslverr_o;
        @(posedge clk_i);
        #1 psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic retire_row(input int idx);
        retire_valid_i    = 1'b1;
        retire_pc_i       = tab_pc[idx];
        retire_instr_i    = tab_instr[idx];
        retire_rd_we_i    = tab_we[idx];
        retire_rd_wdata_i = tab_wdata[idx];
        @(posedge clk_i);
        #1 retire_valid_i = 1'b0;
        retire_rd_we_i = 1'b0;
    endtask

    task automatic read_expect(input logic [7:0] addr, input string name,
                               input logic [31:0] expected);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check(name, data, expected);
        check({name, " pslverr_o"}, 32'(err), 32'd0);
    endtask

    // poll STATUS until the buffer holds the given number of records
    task automatic wait_level(input int level);
        logic [31:0] data;
        logic        err;
        data = '0;
        while (data[7:0] != 8'(level)) begin
            apb_read(`TRACE_ADDR_STATUS, data, err);
        end
    endtask

    task automatic check_record(input int idx, output logic [31:0] cycle);
        logic [31:0] info;
        logic [31:0] wdata;
        logic        err;
        info  = {tab_wb[idx], 2'b00, tab_rs2[idx], 3'b000, tab_rs1[idx], 3'b000,
                 tab_rd[idx], 4'h0, tab_cls[idx]};
        wdata = tab_wb[idx] ? tab_wdata[idx] : 32'h0;
        read_expect(`TRACE_ADDR_PC, "prdata_o PC", tab_pc[idx]);
        read_expect(`TRACE_ADDR_INSTR, "prdata_o INSTR", tab_instr[idx]);
        read_expect(`TRACE_ADDR_INFO, "prdata_o INFO", info);
        read_expect(`TRACE_ADDR_IMM, "prdata_o IMM", tab_imm[idx]);
        read_expect(`TRACE_ADDR_WDATA, "prdata_o WDATA", wdata);
        // reading CYCLE pops the head
        apb_read(`TRACE_ADDR_CYCLE, cycle, err);
        check("CYCLE pslverr_o", 32'(err), 32'd0);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin : main_seq
        logic [31:0] data;
        logic [31:0] cyc;
        logic [31:0] prev_cyc;
        logic        err;
        rst_ni            = 1'b0;
        retire_valid_i    = 1'b0;
        retire_pc_i       = '0;
        retire_instr_i    = '0;
        retire_rd_we_i    = 1'b0;
        retire_rd_wdata_i = '0;
        paddr_i           = '0;
        psel_i            = 1'b0;
        penable_i         = 1'b0;
        pwrite_i          = 1'b0;
        pwdata_i          = '0;
        rng_state         = 32'd40940;
        load_table();
        repeat (3) @(posedge clk_i);
        #1 rst_ni = 1'b1;

        // reset state, nothing captured while disabled
        read_expect(`TRACE_ADDR_STATUS, "prdata_o STATUS", 32'h0);
        read_expect(`TRACE_ADDR_CTRL, "prdata_o CTRL", 32'h0);
        retire_row(0);
        repeat (4) @(posedge clk_i);
        #1 read_expect(`TRACE_ADDR_STATUS, "prdata_o STATUS", 32'h0);

        apb_write(`TRACE_ADDR_CTRL, 32'h1, err);
        check("CTRL write pslverr_o", 32'(err), 32'd0);
        read_expect(`TRACE_ADDR_CTRL, "prdata_o CTRL", 32'h1);

        // one record at a time
        for (int i = 0; i < NUM_ROWS; i++) begin
            retire_row(i);
            wait_level(1);
            check_record(i, cyc);
            read_expect(`TRACE_ADDR_STATUS, "prdata_o STATUS", 32'h0);
        end

        // back to back retires keep order and stamps rise
        for (int i = 0; i < 4; i++) begin
            retire_row(i);
        end
        wait_level(4);
        prev_cyc = '0;
        for (int i = 0; i < 4; i++) begin
            check_record(i, cyc);
            if (i > 0) begin
                check("CYCLE increasing", 32'(cyc > prev_cyc), 32'd1);
            end
            prev_cyc = cyc;
        end

        // overflow, the ninth record waits in the capture stage and the
        // tenth and eleventh are dropped
        for (int i = 0; i < 11; i++) begin
            retire_row(i);
        end
        wait_level(8);
        read_expect(`TRACE_ADDR_STATUS, "prdata_o STATUS", 32'h0000_0208);
        for (int i = 0; i < 9; i++) begin
            check_record(i, cyc);
        end
        read_expect(`TRACE_ADDR_STATUS, "prdata_o STATUS", 32'h0000_0200);

        // error responses
        apb_read(`TRACE_ADDR_PC, data, err);
        check("empty PC prdata_o", data, 32'h0);
        check("empty PC pslverr_o", 32'(err), 32'd1);
        apb_read(`TRACE_ADDR_CYCLE, data, err);
        check("empty CYCLE prdata_o", data, 32'h0);
        check("empty CYCLE pslverr_o", 32'(err), 32'd1);
        apb_read(8'h20, data, err);
        check("unmapped pslverr_o", 32'(err), 32'd1);
        apb_write(`TRACE_ADDR_STATUS, 32'hFFFF_FFFF, err);
        check("STATUS write pslverr_o", 32'(err), 32'd1);
        read_expect(`TRACE_ADDR_STATUS, "prdata_o STATUS", 32'h0000_0200);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- trace_unit.f
+incdir+include
hdl/trace_pkg.sv
hdl/trace_fifo_if.sv
hdl/trace_capture.sv
hdl/trace_fifo.sv
hdl/trace_apb_reader.sv
hdl/trace_unit.sv
tb/trace_unit_assertions.sv
tb/tb_trace_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the trace unit testbench with Verilator.
# The script's exit status is the simulator's exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_trace_unit \
    -f trace_unit.f \
    -o tb_trace_unit

./obj_dir/tb_trace_unit
